// File: zports_pkg.sv
// Shared port addresses, register indices, reset values and bus types, imported by the port RTL
`default_nettype none

package zports_pkg;

	// low address byte of the internal ports
	localparam logic [7:0] PORT_FE     = 8'hFE;
	localparam logic [7:0] PORT_XT     = 8'hAF;   // #nnAF, high byte picks the register
	localparam logic [7:0] PORT_FD     = 8'hFD;   // #7FFD paging and #FFFD ay
	localparam logic [7:0] PORT_KJOY   = 8'h1F;
	localparam logic [7:0] PORT_KMOUSE = 8'hDF;
	localparam logic [7:0] PORT_SDCFG  = 8'h77;
	localparam logic [7:0] PORT_SDDAT  = 8'h57;

	// extended register indices in the high address byte
	localparam logic [7:0] XT_XSTAT   = 8'h00;
	localparam logic [7:0] XT_RAMPAGE = 8'h10;    // covers #10..#13
	localparam logic [7:0] XT_FMADDR  = 8'h15;
	localparam logic [7:0] XT_SYSCONF = 8'h20;
	localparam logic [7:0] XT_MEMCONF = 8'h21;
	localparam logic [7:0] XT_IM2VECT = 8'h25;
	localparam logic [7:0] XT_FDDVIRT = 8'h29;
	localparam logic [7:0] XT_INTMASK = 8'h2A;

	// im2 vector source codes
	localparam logic [2:0] INT_FRM = 3'b000;
	localparam logic [2:0] INT_LIN = 3'b001;
	localparam logic [2:0] INT_DMA = 3'b010;

	// register values after rst
	localparam logic [7:0]  SYSCONF_RST  = 8'h01;          // turbo 7 MHz
	localparam logic [7:0]  MEMCONF_RST  = 8'h04;
	localparam logic [7:0]  INTMASK_RST  = 8'h01;          // frame int only
	localparam logic [2:0]  IM2V_FRM_RST = 3'b111;
	localparam logic [31:0] RAMPAGE_RST  = 32'h0002_0500;  // pages 0..3 = 00 05 02 00

	// one i/o access as seen on clk
	typedef struct packed {
		logic [15:0] a;
		logic [7:0]  din;
		logic        iowr_s;   // one-cycle write strobe
		logic        iord_s;   // one-cycle read strobe
	} io_cycle_t;

	// decoded port flags, at most one set
	typedef struct packed {
		logic fe;
		logic xt;
		logic p7ffd;
		logic ay;
		logic kjoy;
		logic kmouse;
		logic sdcfg;
		logic sddat;
	} port_sel_t;

	typedef struct packed {
		logic [2:0] frm;
		logic [2:0] lin;
		logic [2:0] dma;
	} im2_vect_t;

	// #7FFD layout of the data byte
	typedef struct packed {
		logic [1:0] page_hi;
		logic       lock48;
		logic       rom;
		logic       rsvd;
		logic [2:0] page_lo;
	} p7ffd_byte_t;

	// IM2VECT layout of the data byte
	typedef struct packed {
		logic       rsvd_hi;
		logic [2:0] source;
		logic [2:0] vector;
		logic       rsvd_lo;
	} im2_byte_t;

	// same write byte, three readings
	typedef union packed {
		logic [7:0]  raw;
		p7ffd_byte_t p7ffd;
		im2_byte_t   im2;
	} zdata_u;

endpackage

`default_nettype wire

// File: port_decode.sv
// Low address byte decoder, gives the port-select flags, port hit and external-port flag
`default_nettype none
`timescale 1ns/1ps

module port_decode import zports_pkg::*; (
	input  io_cycle_t bus,
	input  logic      dos,
	output port_sel_t sel,
	output logic      porthit,
	output logic      external_port
);

	logic [7:0] loa;
	logic       fd_hit;

	assign loa    = bus.a[7:0];
	assign fd_hit = (loa == PORT_FD);

	always_comb
	begin
		sel = '0;

		sel.fe     = (loa == PORT_FE);
		sel.xt     = (loa == PORT_XT);
		sel.kmouse = (loa == PORT_KMOUSE);

		// #FD is split by a15
		sel.p7ffd = fd_hit && !bus.a[15];
		sel.ay    = fd_hit &&  bus.a[15];

		// hidden while in dos
		sel.kjoy  = (loa == PORT_KJOY)  && !dos;
		sel.sdcfg = (loa == PORT_SDCFG) && !dos;
		sel.sddat = (loa == PORT_SDDAT) && !dos;
	end

	assign porthit       = |sel;
	assign external_port = sel.ay;   // ay sits on the zx bus

endmodule

`default_nettype wire

// File: xt_regs.sv
// Extended #nnAF configuration registers, #7FFD paging with lock modes and the power-up flag
`default_nettype none
`timescale 1ns/1ps

module xt_regs import zports_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  io_cycle_t   bus,
	input  port_sel_t   sel,
	input  logic        iord_s,
	output logic [31:0] xt_page,
	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [7:0]  intmask,
	output logic [3:0]  fddvirt,
	output logic [4:0]  fmaddr,
	output im2_vect_t   im2v,
	output logic        pwr_up
);

	logic [7:0]      hoa;
	zdata_u          d;
	logic            xt_wr;
	logic            p7ffd_wr;
	logic            lock48;
	logic            mode1;
	logic            mode3;
	logic [2:0]      page3_hi;
	logic [3:0][7:0] rampage;
	logic            pwr_up_r = 1'b1;   // only configuration sets it

	assign hoa = bus.a[15:8];
	assign d   = zdata_u'(bus.din);

	assign xt_wr    = sel.xt && bus.iowr_s;
	assign p7ffd_wr = sel.p7ffd && bus.iowr_s && !lock48;   // frozen once 48k locked

	// lock mode in memconf[7:6], mode 2 runs as unlocked here
	assign mode1 = (memconf[7:6] == 2'b01);
	assign mode3 = (memconf[7:6] == 2'b11);

	// upper page bits of a #7FFD write
	always_comb
	begin
		if (mode3)
			page3_hi = {d.p7ffd.lock48, d.p7ffd.page_hi};   // 1M via bit 5
		else if (mode1)
			page3_hi = 3'b000;                              // 128k only
		else
			page3_hi = {1'b0, d.p7ffd.page_hi};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rampage <= RAMPAGE_RST;
			sysconf <= SYSCONF_RST;
			memconf <= MEMCONF_RST;
			intmask <= INTMASK_RST;
			fddvirt <= '0;
			fmaddr  <= '0;
			im2v    <= '{frm: IM2V_FRM_RST, lin: 3'b000, dma: 3'b000};
			lock48  <= 1'b0;
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= d.p7ffd.rom;
			rampage[3] <= {2'b00, page3_hi, d.p7ffd.page_lo};
			if (!mode3)
				lock48 <= d.p7ffd.lock48;
		end
		else if (xt_wr)
		begin
			if (hoa[7:2] == XT_RAMPAGE[7:2])
				rampage[hoa[1:0]] <= d.raw;
			if (hoa == XT_FMADDR)
				fmaddr <= d.raw[4:0];
			if (hoa == XT_SYSCONF)
				sysconf <= d.raw;
			if (hoa == XT_MEMCONF)
				memconf <= d.raw;
			if (hoa == XT_FDDVIRT)
				fddvirt <= d.raw[3:0];
			if (hoa == XT_INTMASK)
				intmask <= d.raw;
			if (hoa == XT_IM2VECT)
			begin
				// source field names the vector, others left alone
				if (d.im2.source == INT_FRM)
					im2v.frm <= d.im2.vector;
				if (d.im2.source == INT_LIN)
					im2v.lin <= d.im2.vector;
				if (d.im2.source == INT_DMA)
					im2v.dma <= d.im2.vector;
			end
		end
	end

	// cleared by the first status read
	always_ff @(posedge clk)
	begin
		if (iord_s && sel.xt && (hoa == XT_XSTAT))
			pwr_up_r <= 1'b0;
	end

	assign pwr_up  = pwr_up_r;
	assign xt_page = rampage;   // page 3 in the top byte

endmodule

`default_nettype wire

// File: sd_port.sv
// SD card port pair, chip-select register on SDCFG and SPI start/data on SDDAT
`default_nettype none
`timescale 1ns/1ps

module sd_port import zports_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  io_cycle_t  bus,
	input  port_sel_t  sel,
	output logic       sdcs_n,
	output logic       sd_start,
	output logic [7:0] sd_datain
);

	logic sdcfg_wr;
	logic sddat_wr;
	logic sddat_rd;

	// sel already masks these in dos
	assign sdcfg_wr = sel.sdcfg && bus.iowr_s;
	assign sddat_wr = sel.sddat && bus.iowr_s;
	assign sddat_rd = sel.sddat && bus.iord_s;

	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1;            // card deselected
		else if (sdcfg_wr)
			sdcs_n <= bus.din[1];
	end

	assign sd_start  = sddat_wr || sddat_rd;             // one spi byte per access
	assign sd_datain = sddat_wr ? bus.din : 8'hFF;       // reads shift out ones

endmodule

`default_nettype wire

// File: port_readback.sv
// Read-back multiplexer, picks the byte returned to the Z80 on an internal port read
`default_nettype none
`timescale 1ns/1ps

module port_readback import zports_pkg::*; (
	input  io_cycle_t   bus,
	input  port_sel_t   sel,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [7:0]  mus_in,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  sd_dataout,
	input  logic [31:0] xt_page,
	input  logic        pwr_up,
	output logic [7:0]  dout
);

	logic [7:0] hoa;
	logic [7:0] xt_dout;

	assign hoa = bus.a[15:8];

	// #nnAF readable registers
	always_comb
	begin
		case (hoa)
			XT_XSTAT:
				xt_dout = {1'b0, pwr_up, 6'b000000};
			XT_RAMPAGE + 8'd2:
				xt_dout = xt_page[23:16];
			XT_RAMPAGE + 8'd3:
				xt_dout = xt_page[31:24];
			default:
				xt_dout = 8'hFF;
		endcase
	end

	always_comb
	begin
		dout = 8'hFF;   // unknown or write-only ports
		if (sel.fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel.kjoy)
			dout = {3'b000, kj_in};   // kempston
		else if (sel.kmouse)
			dout = mus_in;
		else if (sel.sdcfg)
			dout = 8'h00;             // card present, not write protected
		else if (sel.sddat)
			dout = sd_dataout;
		else if (sel.xt)
			dout = xt_dout;
	end

endmodule

`default_nettype wire

// File: zports.sv
// Top of the Z80 I/O port block, ties decoder, register bank, SD port and read-back together
`default_nettype none
`timescale 1ns/1ps

module zports import zports_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  io_cycle_t   bus,
	input  logic        iord,          // level, whole read cycle
	input  logic        dos,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [7:0]  mus_in,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  sd_dataout,
	output logic [31:0] xt_page,
	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [7:0]  intmask,
	output logic [3:0]  fddvirt,
	output logic [4:0]  fmaddr,
	output im2_vect_t   im2v,
	output logic        pwr_up,
	output logic        sdcs_n,
	output logic        sd_start,
	output logic [7:0]  sd_datain,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic        external_port
);

	port_sel_t sel;

	port_decode i_port_decode (
		.bus           (bus),
		.dos           (dos),
		.sel           (sel),
		.porthit       (porthit),
		.external_port (external_port)
	);

	xt_regs i_xt_regs (
		.clk     (clk),
		.rst     (rst),
		.bus     (bus),
		.sel     (sel),
		.iord_s  (bus.iord_s),
		.xt_page (xt_page),
		.sysconf (sysconf),
		.memconf (memconf),
		.intmask (intmask),
		.fddvirt (fddvirt),
		.fmaddr  (fmaddr),
		.im2v    (im2v),
		.pwr_up  (pwr_up)
	);

	sd_port i_sd_port (
		.clk       (clk),
		.rst       (rst),
		.bus       (bus),
		.sel       (sel),
		.sdcs_n    (sdcs_n),
		.sd_start  (sd_start),
		.sd_datain (sd_datain)
	);

	port_readback i_port_readback (
		.bus        (bus),
		.sel        (sel),
		.keys_in    (keys_in),
		.tape_read  (tape_read),
		.mus_in     (mus_in),
		.kj_in      (kj_in),
		.sd_dataout (sd_dataout),
		.xt_page    (xt_page),
		.pwr_up     (pwr_up),
		.dout       (dout)
	);

	// drive the data bus only for internal ports, ay answers on its own
	assign dataout = porthit && iord && !external_port;

endmodule

`default_nettype wire

// File: tb_clock.sv
// Testbench clock source, free-running 4 ns clock for the port block testbench
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;   // half of the 4 ns period

endmodule

`default_nettype wire

// File: tb_zports.sv
// Testbench for the I/O port block that replays the port trace on falling edges and checks the DUT
`default_nettype none
`timescale 1ns/1ps

module tb_zports import zports_pkg::*; ();

	localparam logic [31:0] SEED = 32'h03f48212;

	logic        clk;
	logic        rst;
	io_cycle_t   bus;
	logic        iord;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [7:0]  mus_in;
	logic [4:0]  kj_in;
	logic [7:0]  sd_dataout;
	logic [31:0] xt_page;
	logic [7:0]  sysconf;
	logic [7:0]  memconf;
	logic [7:0]  intmask;
	logic [3:0]  fddvirt;
	logic [4:0]  fmaddr;
	im2_vect_t   im2v;
	logic        pwr_up;
	logic        sdcs_n;
	logic        sd_start;
	logic [7:0]  sd_datain;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic        external_port;

	// one entry per trace line
	logic [7:0]  op_q[$];
	logic [15:0] addr_q[$];
	logic [7:0]  data_q[$];
	logic        dos_q[$];
	logic [31:0] exp_q[$];

	int step   = 0;
	int cycles = 0;
	int limit  = 100;   // raised once the trace is loaded

	tb_clock i_clock (.clk(clk));

	zports i_zports (.*);

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout, the trace did not finish within %0d cycles", limit);
			$display("=== FAIL ===");
			$fatal(1, "cycle limit reached");
		end
	end

	// what a peripheral port should return for the drawn inputs
	function automatic logic [7:0] peripheral_byte(input logic [7:0] port);
		case (port)
			8'hFE:   return {1'b1, tape_read, 1'b0, keys_in};
			8'h1F:   return {3'b000, kj_in};
			8'hDF:   return mus_in;
			8'h57:   return sd_dataout;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic logic [31:0] output_word(input logic [3:0] idx);
		case (idx)
			4'd0:    return xt_page;
			4'd1:    return {24'd0, sysconf};
			4'd2:    return {24'd0, memconf};
			4'd3:    return {24'd0, intmask};
			4'd4:    return {28'd0, fddvirt};
			4'd5:    return {27'd0, fmaddr};
			4'd6:    return {23'd0, im2v};
			4'd7:    return {31'd0, sdcs_n};
			default: return {31'd0, pwr_up};
		endcase
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] want);
		$display("ERROR at %0t: step %0d, %s = %0h, expected %0h", $time, step, what, got, want);
		$display("=== FAIL ===");
		$fatal(1, "mismatch in the port trace");
	endtask

	task automatic load_trace();
		int          fd;
		int          n;
		string       line;
		string       op_s;
		int unsigned f_addr;
		int unsigned f_data;
		int unsigned f_dos;
		int unsigned f_exp;
		fd = $fopen("zports_trace.txt", "r");
		if (fd == 0)
		begin
			$display("the trace file zports_trace.txt could not be opened");
			$display("=== FAIL ===");
			$fatal(1, "missing trace file");
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() < 2 || line[0] == "#")
					continue;   // blank or comment
				n = $sscanf(line, "%s %h %h %h %h", op_s, f_addr, f_data, f_dos, f_exp);
				if (n != 5)
				begin
					$display("a trace line could not be read: %s", line);
					$display("=== FAIL ===");
					$fatal(1, "unreadable trace file");
				end
				else
				begin
					op_q.push_back(op_s[0]);
					addr_q.push_back(f_addr[15:0]);
					data_q.push_back(f_data[7:0]);
					dos_q.push_back(f_dos[0]);
					exp_q.push_back(f_exp);
				end
			end
			$fclose(fd);
		end
	endtask

	// one bus cycle, falling edge to falling edge
	task automatic drive_bus(input logic [15:0] addr, input logic [7:0] data,
		input logic wr, input logic rd, input logic d);
		@(negedge clk);
		bus.a      = addr;
		bus.din    = data;
		bus.iowr_s = wr;
		bus.iord_s = rd;
		iord       = rd;
		dos        = d;
		#1;   // comb outputs settle well before the rising edge
	endtask

	task automatic apply_write(input logic [15:0] addr, input logic [7:0] data,
		input logic d, input logic [31:0] want);
		drive_bus(addr, data, 1'b1, 1'b0, d);
		assert ({sd_start, sd_datain} == want[8:0])
		else
			report_mismatch("sd_start/sd_datain", {23'd0, sd_start, sd_datain}, want);
		// no read cycle, so the data bus stays released
		assert (dataout == 1'b0)
		else
			report_mismatch("dataout on write", {31'd0, dataout}, 32'd0);
	endtask

	task automatic apply_read(input logic [15:0] addr, input logic d,
		input logic [31:0] want, input logic periph);
		logic [7:0] want_dout;
		drive_bus(addr, 8'h00, 1'b0, 1'b1, d);
		want_dout = periph ? peripheral_byte(addr[7:0]) : want[7:0];
		assert ({porthit, external_port, dataout, sd_start} == want[11:8])
		else
			report_mismatch("port flags", {28'd0, porthit, external_port, dataout, sd_start},
				{28'd0, want[11:8]});
		assert (dout == want_dout)
		else
			report_mismatch("dout", {24'd0, dout}, {24'd0, want_dout});
		assert (sd_datain == 8'hFF)
		else
			report_mismatch("sd_datain on read", {24'd0, sd_datain}, 32'hFF);
	endtask

	task automatic check_output(input logic [3:0] idx, input logic d, input logic [31:0] want);
		drive_bus(16'h0000, 8'h00, 1'b0, 1'b0, d);
		if (idx > 4'd8)
		begin
			$display("the trace names an unknown output index %0d", idx);
			$display("=== FAIL ===");
			$fatal(1, "bad output index");
		end
		else
		begin
			assert (output_word(idx) == want)
			else
				report_mismatch($sformatf("output %0d", idx), output_word(idx), want);
		end
	endtask

	task automatic pulse_reset();
		@(negedge clk);
		bus  = '0;
		iord = 1'b0;
		rst  = 1'b1;
		@(negedge clk);
		rst  = 1'b0;
	endtask

	initial
	begin
		int unsigned rnd;
		rnd = $urandom(SEED);
		rnd = $urandom();
		keys_in    = rnd[4:0];   // peripheral inputs stay fixed for the run
		kj_in      = rnd[9:5];
		tape_read  = rnd[10];
		mus_in     = rnd[18:11];
		sd_dataout = rnd[26:19];
		rst  = 1'b1;
		bus  = '0;
		iord = 1'b0;
		dos  = 1'b0;
		load_trace();
		limit = 4 * op_q.size() + 100;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < op_q.size(); i++)
		begin
			step = i + 1;
			case (op_q[i])
				"w": apply_write(addr_q[i], data_q[i], dos_q[i], exp_q[i]);
				"r": apply_read(addr_q[i], dos_q[i], exp_q[i], 1'b0);
				"p": apply_read(addr_q[i], dos_q[i], exp_q[i], 1'b1);
				"c": check_output(addr_q[i][3:0], dos_q[i], exp_q[i]);
				"z": pulse_reset();
				default:
				begin
					$display("unknown operation %c at trace step %0d", op_q[i], step);
					$display("=== FAIL ===");
					$fatal(1, "bad trace operation");
				end
			endcase
		end
		@(negedge clk);
		bus  = '0;
		iord = 1'b0;
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: zports_trace.txt
# op addr data dos expect; op w write, r read, p peripheral read, c check output[addr], z reset
# expect w {sd_start,sd_datain}, r/p {hit,ext,dataout,sd_start,dout}, c output value
c 0000 00 0 00020500
c 0001 00 0 01
c 0002 00 0 04
c 0003 00 0 01
c 0006 00 0 1C0
c 0007 00 0 1
w 10AF 11 0 0FF
w 13AF 44 0 0FF
c 0000 00 0 44020511
r 12AF 00 0 A02
r 13AF 00 0 A44
w 15AF 3F 0 0FF
c 0005 00 0 1F
w 20AF 03 0 0FF
c 0001 00 0 03
w 29AF 5A 0 0FF
c 0004 00 0 0A
w 2AAF 07 0 0FF
c 0003 00 0 07
r 30AF 00 0 AFF
w 25AF 1A 0 0FF
c 0006 00 0 1E8
w 25AF 26 0 0FF
c 0006 00 0 1EB
w 25AF 5E 0 0FF
c 0006 00 0 1EB
w 21AF C0 0 0FF
w 7FFD B5 0 0FF
c 0000 00 0 35020511
c 0002 00 0 C1
w 21AF 40 0 0FF
w 7FFD C3 0 0FF
c 0000 00 0 03020511
w 21AF 80 0 0FF
w 7FFD 52 0 0FF
c 0000 00 0 0A020511
c 0002 00 0 81
w 7FFD 21 0 0FF
c 0000 00 0 01020511
w 7FFD 17 0 0FF
c 0000 00 0 01020511
c 0002 00 0 80
p 00FE 00 0 A00
p 001F 00 0 A00
r 001F 00 1 0FF
p 00DF 00 0 A00
p 0057 00 0 B00
r 0077 00 0 A00
r FFFD 00 0 CFF
r 00FB 00 0 0FF
w 0077 00 0 0FF
c 0007 00 0 0
w 0077 02 1 0FF
c 0007 00 0 0
w 0077 02 0 0FF
c 0007 00 0 1
w 0057 A5 0 1A5
w 0057 3C 1 0FF
r 00AF 00 0 A40
r 00AF 00 0 A00
z 0000 00 0 0
c 0000 00 0 00020500
c 0008 00 0 0
w 7FFD 07 0 0FF
c 0000 00 0 07020500

// File: sources.f
zports_pkg.sv
port_decode.sv
xt_regs.sv
sd_port.sv
port_readback.sv
zports.sv
tb_clock.sv
tb_zports.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_zports
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
